// File: Makefile
TOOL    := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := ifu_tb
FLIST   := verilog.f
OBJDIR  := obj_dir
LOG     := sim.log
RUNARGS := +verilator+error+limit+1000

.PHONY: sim clean

# build, run, then decide on the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: logic/ifu_align.sv
`timescale 1ns/1ps

module ifu_align (
	input  logic                clk,
	input  logic                rst_n,
	input  ifu_pkg::fetch_req_t rsp_req,
	input  ifu_pkg::word_t      rsp_word,
	input  ifu_pkg::epoch_t     cur_epoch,
	output logic                out_valid,
	output ifu_pkg::fetch_pkt_t out_pkt,
	output logic                drop
);
	import ifu_pkg::*;

	// rv64 opcodes of interest
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	inst_t inst_sel;
	logic  ctrl;
	logic  accept;
	logic  stale;

	// ****************************************
	// half-word select
	// ****************************************

	// bit 2 picks the upper instruction of the word
	assign inst_sel = rsp_req.pc[2] ? rsp_word[63:32] : rsp_word[31:0];

	// ****************************************
	// control transfer classification
	// ****************************************

	always_comb begin
		ctrl = 1'b0;
		case (inst_sel[6:0])
			// jal, any encoding
			OP_JAL:
				ctrl = 1'b1;
			// jalr needs funct3 000
			OP_JALR:
				ctrl = (inst_sel[14:12] == 3'b000);
			// beq bne blt bge bltu bgeu
			// funct3 010 and 011 are reserved
			OP_BRANCH:
				ctrl = (inst_sel[14:13] != 2'b01);
			default:
				ctrl = 1'b0;
		endcase
	end

	// ****************************************
	// epoch filter and output register
	// ****************************************

	// response from the current path goes to decode
	assign accept = rsp_req.valid && (rsp_req.epoch == cur_epoch);
	// response from before a redirect is thrown away
	assign stale  = rsp_req.valid && (rsp_req.epoch != cur_epoch);

	// control side, drop hands the credit back to the pc stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			drop      <= 1'b0;
		end else begin
			out_valid <= accept;
			drop      <= stale;
		end
	end

	// packet payload, only meaningful with out_valid
	always_ff @(posedge clk) begin
		if (accept) begin
			out_pkt.pc      <= rsp_req.pc;
			out_pkt.inst    <= inst_sel;
			out_pkt.is_ctrl <= ctrl;
		end
	end

endmodule

// File: logic/ifu_config.svh
`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

// first fetch address out of reset
`define IFU_RESET_PC 64'h0000_0000_8000_0000

// datapath width of the core
`define IFU_XLEN 64

// instruction ram geometry, 64-bit words
`define IFU_IMEM_DEPTH 256
// word index width, log2 of depth
`define IFU_IMEM_AW 8

// decode buffer depth, one credit per slot
`define IFU_CREDITS 4
// counter width, must hold IFU_CREDITS
`define IFU_CREDIT_W 3

`endif

// File: logic/ifu_imem.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module ifu_imem (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load_en,
	input  ifu_pkg::widx_t      load_idx,
	input  ifu_pkg::word_t      load_data,
	input  ifu_pkg::fetch_req_t req,
	output ifu_pkg::fetch_req_t rsp_req,
	output ifu_pkg::word_t      rsp_word
);
	import ifu_pkg::*;

	// ****************************************
	// storage
	// ****************************************

	// 64-bit words, two instructions each
	word_t mem [`IFU_IMEM_DEPTH];

	// byte address to word index
	// upper pc bits ignored, address wraps at depth
	widx_t rd_idx;
	assign rd_idx = req.pc[`IFU_IMEM_AW+2:3];

	// back-door load port
	// only used while fetch is held off
	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_idx] <= load_data;
	end

	// ****************************************
	// read port
	// ****************************************

	// registered read, only on a real request
	always_ff @(posedge clk) begin
		if (req.valid)
			rsp_word <= mem[rd_idx];
	end

	// request rides along with its data
	// valid bit must be clean after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_req <= '0;
		else
			rsp_req <= req;
	end

endmodule

// File: logic/ifu_pc.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module ifu_pc (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                fetch_en,
	input  logic                pc_update,
	input  ifu_pkg::addr_t      dnpc,
	input  logic                credit_ret,
	input  logic                drop,
	output ifu_pkg::fetch_req_t req,
	output ifu_pkg::epoch_t     cur_epoch
);
	import ifu_pkg::*;

	// architectural fetch pointer
	addr_t   pc_q;
	// toggles on every redirect
	epoch_t  epoch_q;
	// free slots in decode buffer, minus in flight
	credit_t credit_q;
	credit_t credit_next;
	logic    issue;
	// one spare bit so return plus refund cannot wrap
	logic [`IFU_CREDIT_W:0] credit_sum;

	// ****************************************
	// issue decision
	// ****************************************

	// redirect cycle is a bubble
	// no credit means decode may not be able to take the packet
	assign issue = fetch_en && (credit_q != '0) && !pc_update;

	// request goes out in the same cycle as the decision
	always_comb begin
		req.valid = issue;
		req.pc    = pc_q;
		req.epoch = epoch_q;
	end

	// align compares against the epoch that will be live after this edge,
	// so the response sitting in the ram register during a redirect is
	// already treated as stale
	assign cur_epoch = epoch_q ^ pc_update;

	// ****************************************
	// credit accounting
	// ****************************************

	always_comb begin
		// returns from decode and refunds for dropped packets
		credit_sum = {1'b0, credit_q} + {{`IFU_CREDIT_W{1'b0}}, credit_ret}
			+ {{`IFU_CREDIT_W{1'b0}}, drop} - {{`IFU_CREDIT_W{1'b0}}, issue};
		// saturate at buffer depth
		if (credit_sum > (`IFU_CREDIT_W+1)'(`IFU_CREDITS))
			credit_next = credit_t'(`IFU_CREDITS);
		else
			credit_next = credit_sum[`IFU_CREDIT_W-1:0];
	end

	// ****************************************
	// state registers
	// ****************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q     <= `IFU_RESET_PC;
			epoch_q  <= '0;
			credit_q <= credit_t'(`IFU_CREDITS);
		end else begin
			// redirect wins over sequential advance
			if (pc_update) begin
				pc_q    <= dnpc;
				epoch_q <= ~epoch_q;
			end else if (issue) begin
				pc_q <= pc_q + addr_t'(4);
			end
			credit_q <= credit_next;
		end
	end

endmodule

// File: logic/ifu_pkg.sv
`include "ifu_config.svh"

package ifu_pkg;

	// ****************************************
	// basic vector types
	// ****************************************

	// byte address, pc and dnpc
	typedef logic [`IFU_XLEN-1:0] addr_t;
	// one rv instruction
	typedef logic [31:0] inst_t;
	// one instruction ram word, two instructions
	typedef logic [`IFU_XLEN-1:0] word_t;
	// ram word index
	typedef logic [`IFU_IMEM_AW-1:0] widx_t;
	// decode buffer credits
	typedef logic [`IFU_CREDIT_W-1:0] credit_t;
	// redirect generation
	typedef logic epoch_t;

	// ****************************************
	// bundles between the stages
	// ****************************************

	// fetch request, pc stage to ram and on to align
	typedef struct packed {
		logic   valid;
		addr_t  pc;
		epoch_t epoch;
	} fetch_req_t;

	// packet handed to decode
	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  is_ctrl;
	} fetch_pkt_t;

endpackage

// File: logic/ifu_top.sv
`timescale 1ns/1ps

module ifu_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                fetch_en,
	input  logic                pc_update,
	input  ifu_pkg::addr_t      dnpc,
	input  logic                credit_ret,
	input  logic                load_en,
	input  ifu_pkg::widx_t      load_idx,
	input  ifu_pkg::word_t      load_data,
	output logic                out_valid,
	output ifu_pkg::fetch_pkt_t out_pkt
);
	import ifu_pkg::*;

	// pc stage to ram
	fetch_req_t req;
	// ram to align
	fetch_req_t rsp_req;
	word_t      rsp_word;
	// align back to pc stage
	logic       drop;
	epoch_t     cur_epoch;

	// ****************************************
	// fetch pointer and credits
	// ****************************************

	ifu_pc u_pc (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_en   (fetch_en),
		.pc_update  (pc_update),
		.dnpc       (dnpc),
		.credit_ret (credit_ret),
		.drop       (drop),
		.req        (req),
		.cur_epoch  (cur_epoch)
	);

	// instruction ram, one cycle read
	ifu_imem u_imem (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_idx  (load_idx),
		.load_data (load_data),
		.req       (req),
		.rsp_req   (rsp_req),
		.rsp_word  (rsp_word)
	);

	// select, classify, filter
	ifu_align u_align (
		.clk       (clk),
		.rst_n     (rst_n),
		.rsp_req   (rsp_req),
		.rsp_word  (rsp_word),
		.cur_epoch (cur_epoch),
		.out_valid (out_valid),
		.out_pkt   (out_pkt),
		.drop      (drop)
	);

endmodule

// File: verif/ifu_asserts.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module ifu_asserts #(
	// credit checks when bound to the pc stage, output checks otherwise
	parameter bit PC_SIDE = 1'b1
) (
	input logic                clk,
	input logic                rst_n,
	input ifu_pkg::credit_t    credit,
	input logic                issue,
	input logic                out_valid,
	input logic                drop
);
	import ifu_pkg::*;

	// one failure counter per property
	int credit_fail = 0;
	int issue_fail  = 0;
	int excl_fail   = 0;
	int quiet_fail  = 0;
	// summed for the testbench summary
	int fail_cnt;

	always_comb fail_cnt = credit_fail + issue_fail + excl_fail + quiet_fail;

	generate
		if (PC_SIDE) begin : g_pc_side

			// ****************************************
			// credit accounting
			// ****************************************

			// counter saturates at decode buffer depth
			credit_max: assert property (@(posedge clk) disable iff (!rst_n)
				credit <= credit_t'(`IFU_CREDITS))
			else begin
				$error("credit count above decode buffer depth");
				credit_fail++;
			end

			// empty counter blocks issue
			no_issue_empty: assert property (@(posedge clk) disable iff (!rst_n)
				(credit == '0) |-> !issue)
			else begin
				$error("fetch request issued with zero credits");
				issue_fail++;
			end

		end else begin : g_out_side

			// ****************************************
			// output side
			// ****************************************

			// a response is either delivered or dropped, never both
			valid_drop_excl: assert property (@(posedge clk) disable iff (!rst_n)
				!(out_valid && drop))
			else begin
				$error("out_valid and drop high in the same cycle");
				excl_fail++;
			end

			// nothing leaves the unit while reset is held
			reset_quiet: assert property (@(posedge clk)
				!rst_n |-> (!out_valid && !drop))
			else begin
				$error("output activity during reset");
				quiet_fail++;
			end

		end
	endgenerate

endmodule

// pc stage, credits and issue
bind ifu_pc ifu_asserts #(.PC_SIDE(1'b1)) u_pc_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.credit    (credit_q),
	.issue     (issue),
	.out_valid (1'b0),
	.drop      (1'b0)
);

// align stage, packet and drop outputs
bind ifu_align ifu_asserts #(.PC_SIDE(1'b0)) u_align_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.credit    ('0),
	.issue     (1'b0),
	.out_valid (out_valid),
	.drop      (drop)
);

// File: verif/ifu_tb.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module ifu_tb;
	import ifu_pkg::*;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       fetch_en;
	logic       pc_update;
	addr_t      dnpc;
	logic       credit_ret;
	logic       load_en;
	widx_t      load_idx;
	word_t      load_data;
	logic       out_valid;
	fetch_pkt_t out_pkt;

	// testbench copy of the instruction ram
	word_t       mem_copy [`IFU_IMEM_DEPTH];
	// next pc decode should see
	addr_t       exp_pc;
	// decode buffer model, occupancy is pushed minus popped
	int          pushed_cnt = 0;
	int          popped_cnt = 0;
	int unsigned pop_pct;
	int          cmp_err = 0;
	int          tst_err;
	int          n_pass;
	int          n_fail;
	int          err0;

	always #5 clk = ~clk;

	ifu_top dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_en   (fetch_en),
		.pc_update  (pc_update),
		.dnpc       (dnpc),
		.credit_ret (credit_ret),
		.load_en    (load_en),
		.load_idx   (load_idx),
		.load_data  (load_data),
		.out_valid  (out_valid),
		.out_pkt    (out_pkt)
	);

	// ****************************************
	// reference model
	// ****************************************

	// expected packet for a fetch address
	function automatic fetch_pkt_t expect_pkt(input addr_t pc);
		fetch_pkt_t p;
		word_t      w;
		logic [6:0] op;
		logic [2:0] f3;
		// word index wraps at ram depth
		w         = mem_copy[pc[`IFU_IMEM_AW+2:3]];
		p.pc      = pc;
		p.inst    = pc[2] ? w[63:32] : w[31:0];
		op        = p.inst[6:0];
		f3        = p.inst[14:12];
		p.is_ctrl = (op == 7'b1101111)
			|| (op == 7'b1100111 && f3 == 3'd0)
			|| (op == 7'b1100011 && f3 != 3'd2 && f3 != 3'd3);
		return p;
	endfunction

	// instruction mix for the classification test
	function automatic inst_t ctrl_inst(input int n);
		inst_t r;
		r = $urandom;
		case (n % 5)
			0: r[6:0] = 7'b1101111;
			1: begin
				r[6:0]   = 7'b1100111;
				r[14:12] = 3'd0;
			end
			2: begin
				r[6:0]   = 7'b1100111;
				r[14:12] = 3'($urandom_range(7, 1));
			end
			// walks all eight funct3 values, reserved ones included
			3: begin
				r[6:0]   = 7'b1100011;
				r[14:12] = 3'((n / 5) % 8);
			end
			default: ;
		endcase
		return r;
	endfunction

	function automatic int total_errors();
		return cmp_err + tst_err + dut.u_pc.u_pc_chk.fail_cnt
			+ dut.u_align.u_align_chk.fail_cnt;
	endfunction

	// ****************************************
	// comparator, sampled mid-cycle
	// ****************************************

	always @(negedge clk) begin
		fetch_pkt_t want;
		if (!rst_n) begin
			exp_pc = `IFU_RESET_PC;
		end else begin
			if (out_valid) begin
				want = expect_pkt(exp_pc);
				assert (out_pkt.pc == want.pc) else begin
					$display("Mismatch at %0t: out_pkt.pc got %h expected %h",
						$time, out_pkt.pc, want.pc);
					cmp_err++;
				end
				assert (out_pkt.inst == want.inst) else begin
					$display("Mismatch at %0t: out_pkt.inst got %h expected %h",
						$time, out_pkt.inst, want.inst);
					cmp_err++;
				end
				assert (out_pkt.is_ctrl == want.is_ctrl) else begin
					$display("Mismatch at %0t: out_pkt.is_ctrl got %b expected %b",
						$time, out_pkt.is_ctrl, want.is_ctrl);
					cmp_err++;
				end
				pushed_cnt++;
				exp_pc = exp_pc + addr_t'(4);
				assert (pushed_cnt - popped_cnt <= `IFU_CREDITS) else begin
					$display("decode buffer overflow at %0t, %0d packets unreturned",
						$time, pushed_cnt - popped_cnt);
					cmp_err++;
				end
			end
			// packet of this cycle still belongs to the old path
			if (pc_update)
				exp_pc = dnpc;
		end
	end

	// decode side, pops at random and returns one credit per pop
	initial begin
		credit_ret = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			credit_ret = 1'b0;
			if (rst_n && (pushed_cnt > popped_cnt) && (($urandom % 100) < pop_pct)) begin
				credit_ret = 1'b1;
				popped_cnt++;
			end
		end
	end

	// ****************************************
	// stimulus helpers
	// ****************************************

	// inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic abort(input string what);
		$display("timeout: %s", what);
		$display("sim failed");
		$finish;
	endtask

	// mode 0 random words, otherwise the control-transfer mix
	task automatic load_program(input int mode);
		word_t w;
		for (int i = 0; i < `IFU_IMEM_DEPTH; i++) begin
			if (mode == 0)
				w = {$urandom, $urandom};
			else
				w = {ctrl_inst(2 * i + 1), ctrl_inst(2 * i)};
			mem_copy[i] = w;
			load_en     = 1'b1;
			load_idx    = widx_t'(i);
			load_data   = w;
			step();
		end
		load_en = 1'b0;
	endtask

	task automatic redirect(input addr_t target);
		pc_update = 1'b1;
		dnpc      = target;
		step();
		pc_update = 1'b0;
	endtask

	task automatic wait_packets(input int n, input int limit);
		int target;
		int cycles;
		target = pushed_cnt + n;
		cycles = 0;
		while (pushed_cnt < target && cycles < limit) begin
			step();
			cycles++;
		end
		if (pushed_cnt < target)
			abort("packets from the fetch unit stopped arriving");
	endtask

	// fetch off, buffer drained, output quiet for a few cycles
	task automatic wait_idle();
		int quiet;
		int cycles;
		fetch_en  = 1'b0;
		pc_update = 1'b0;
		pop_pct   = 100;
		quiet     = 0;
		cycles    = 0;
		while ((quiet < 4 || pushed_cnt != popped_cnt) && cycles < 200) begin
			step();
			quiet = out_valid ? 0 : quiet + 1;
			cycles++;
		end
		if (quiet < 4 || pushed_cnt != popped_cnt)
			abort("fetch unit did not go idle");
	endtask

	task automatic wait_full();
		int cycles;
		cycles = 0;
		while (pushed_cnt - popped_cnt < `IFU_CREDITS && cycles < 100) begin
			step();
			cycles++;
		end
		if (pushed_cnt - popped_cnt < `IFU_CREDITS)
			abort("decode buffer never filled under back-pressure");
	endtask

	task automatic finish_test(input string name);
		if (total_errors() == err0) begin
			$display("test %s: ok", name);
			n_pass++;
		end else begin
			$display("test %s: FAIL, %0d errors", name, total_errors() - err0);
			n_fail++;
		end
	endtask

	// ****************************************
	// test sequence
	// ****************************************

	initial begin
		int base;
		void'($urandom(62363));
		rst_n     = 1'b0;
		fetch_en  = 1'b0;
		pc_update = 1'b0;
		dnpc      = '0;
		load_en   = 1'b0;
		load_idx  = '0;
		load_data = '0;
		pop_pct   = 100;
		tst_err   = 0;
		n_pass    = 0;
		n_fail    = 0;
		repeat (10) step();
		rst_n = 1'b1;

		// sequential stream from the reset pc
		err0 = total_errors();
		load_program(0);
		fetch_en = 1'b1;
		wait_packets(40, 400);
		wait_idle();
		finish_test("reset_sequence");

		// decode withholds credits
		err0     = total_errors();
		pop_pct  = 0;
		fetch_en = 1'b1;
		wait_full();
		base = pushed_cnt;
		repeat (20) step();
		assert (pushed_cnt == base) else begin
			$display("packets delivered at %0t with no credits left", $time);
			tst_err++;
		end
		pop_pct = 50;
		wait_packets(24, 400);
		wait_idle();
		finish_test("back_pressure");

		// redirect in the middle of a running stream
		err0     = total_errors();
		fetch_en = 1'b1;
		wait_packets(8, 100);
		redirect(`IFU_RESET_PC + addr_t'($urandom & 32'h7fc));
		wait_packets(12, 100);
		wait_idle();
		finish_test("redirect");

		// jal, jalr, every branch funct3
		err0 = total_errors();
		load_program(1);
		redirect(`IFU_RESET_PC);
		fetch_en = 1'b1;
		wait_packets(2 * `IFU_IMEM_DEPTH, 2000);
		wait_idle();
		finish_test("ctrl_classify");

		// random redirects, pops and fetch enable
		err0 = total_errors();
		for (int c = 0; c < 3000; c++) begin
			step();
			if (c % 200 == 0)
				pop_pct = $urandom_range(90, 0);
			fetch_en  = ($urandom % 10) < 8;
			pc_update = ($urandom % 100) < 4;
			dnpc      = `IFU_RESET_PC + addr_t'($urandom & 32'h7fc);
		end
		pc_update = 1'b0;
		wait_idle();
		finish_test("random_mix");

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			n_pass + n_fail, n_pass, n_fail, total_errors());
		if (n_fail == 0 && total_errors() == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+logic
logic/ifu_pkg.sv
logic/ifu_pc.sv
logic/ifu_imem.sv
logic/ifu_align.sv
logic/ifu_top.sv
verif/ifu_asserts.sv
verif/ifu_tb.sv
